//--- source/kbd_pkg.sv
/*
  Shared constants and the port B register layout for the XT keyboard path.
  The decode covers only the 0x60-0x7F PPI window, and offset 3 is not answered.
  The over-time limit counts cycles of the single system clock.
*/
package kbd_pkg;

    // bus and keycode widths
    localparam int data_w_c = 8;
    localparam int addr_w_c = 10;

    // address bits 7..5 for the PPI window
    localparam logic [2:0] ppi_window_c = 3'b011;

    // register offsets inside the window
    localparam logic [1:0] port_a_ofs_c = 2'd0;
    localparam logic [1:0] port_b_ofs_c = 2'd1;
    localparam logic [1:0] port_c_ofs_c = 2'd2;

    // port B control bit positions
    localparam int clr_bit_c    = 7;
    localparam int kbd_en_bit_c = 6;

    // idle cycles before a partial frame is dropped
    localparam logic [15:0] ps2_over_time_c = 16'd1000;
    // data, parity and stop bits after the start bit
    localparam logic [3:0]  frame_bits_c    = 4'd10;

    // receive FSM state codes
    localparam logic [1:0] st_idle_c   = 2'd0;
    localparam logic [1:0] st_data_c   = 2'd1;
    localparam logic [1:0] st_parity_c = 2'd2;
    localparam logic [1:0] st_stop_c   = 2'd3;

    // port B seen as a byte or as control fields
    typedef union packed {
        logic [data_w_c-1:0] raw;
        struct packed {
            logic       clr;
            logic       kbd_en;
            logic [5:0] spare;
        } ctl;
    } port_b_t;

endpackage

//--- source/ps2_bit_timer.sv
/*
  Synchronizes the PS/2 lines and marks each falling clock edge.
  The fall pulse comes 3 cycles after the pin falls, data is aligned to it.
  over_time_o fires once per stalled frame and only while busy_i is high.
*/
`timescale 1ns/10ps

module ps2_bit_timer import kbd_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic ps2_clock_i,
    input  logic ps2_data_i,
    input  logic busy_i,
    output logic ps2_fall_o,
    output logic ps2_data_sync_o,
    output logic over_time_o
);

    logic        clk_meta;
    logic        clk_sync;
    logic        clk_prev;
    logic        data_meta;
    logic        data_sync;
    logic        fall_next;
    logic [15:0] idle_cnt;
    logic [15:0] idle_next;

    // high to low seen on the synchronized clock
    assign fall_next = clk_prev & ~clk_sync;

    // two flops per line, then the edge flop
    always_ff @(posedge clock) begin
        if (reset) begin
            clk_meta        <= 1'b1;
            clk_sync        <= 1'b1;
            clk_prev        <= 1'b1;
            data_meta       <= 1'b1;
            data_sync       <= 1'b1;
            ps2_fall_o      <= 1'b0;
            ps2_data_sync_o <= 1'b1;
        end else begin
            clk_meta        <= ps2_clock_i;
            clk_sync        <= clk_meta;
            clk_prev        <= clk_sync;
            data_meta       <= ps2_data_i;
            data_sync       <= data_meta;
            ps2_fall_o      <= fall_next;
            ps2_data_sync_o <= data_sync;
        end
    end

    // idle counter, restarts on every fall, saturates at the limit
    always_comb begin
        if (!busy_i || fall_next) begin
            idle_next = 16'd0;
        end else if (idle_cnt != ps2_over_time_c) begin
            idle_next = idle_cnt + 16'd1;
        end else begin
            idle_next = idle_cnt;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            idle_cnt    <= 16'd0;
            over_time_o <= 1'b0;
        end else begin
            idle_cnt    <= idle_next;
            // one pulse as the counter steps onto the limit
            over_time_o <= (idle_next == ps2_over_time_c) && (idle_cnt != ps2_over_time_c);
        end
    end

    a_no_fall_at_over_time: assert property (@(posedge clock) disable iff (reset)
        !(over_time_o && ps2_fall_o));

endmodule

//--- source/ps2_frame_fsm.sv
/*
  Receives one PS/2 frame: start 0, eight data bits LSB first, odd parity, stop 1.
  A bad parity or stop bit, or an over-time pulse, drops the frame silently.
  rx_data_o is only meaningful in the cycle of rx_valid_o.
*/
`timescale 1ns/10ps

module ps2_frame_fsm import kbd_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  logic                ps2_fall_i,
    input  logic                ps2_data_i,
    input  logic                over_time_i,
    output logic                busy_o,
    output logic                rx_valid_o,
    output logic [data_w_c-1:0] rx_data_o
);

    logic [1:0]          state;
    logic [3:0]          bit_cnt;
    logic [data_w_c-1:0] shift_q;
    logic                parity_ok;

    // data bits plus the parity bit must hold an odd count of ones
    assign parity_ok = ^{shift_q, ps2_data_i};

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= st_idle_c;
            bit_cnt <= 4'd0;
        end else if (over_time_i) begin
            // stalled frame, start over
            state   <= st_idle_c;
            bit_cnt <= 4'd0;
        end else if (ps2_fall_i) begin
            case (state)
                st_idle_c: begin
                    // only a low start bit opens a frame
                    if (!ps2_data_i) begin
                        state   <= st_data_c;
                        bit_cnt <= 4'd0;
                    end
                end
                st_data_c: begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt == 4'(data_w_c - 1)) begin
                        state <= st_parity_c;
                    end
                end
                st_parity_c: begin
                    if (parity_ok) begin
                        bit_cnt <= bit_cnt + 4'd1;
                        state   <= st_stop_c;
                    end else begin
                        bit_cnt <= 4'd0;
                        state   <= st_idle_c;
                    end
                end
                default: begin
                    // stop bit, good or not the frame is over
                    bit_cnt <= 4'd0;
                    state   <= st_idle_c;
                end
            endcase
        end
    end

    // LSB arrives first, shift in from the top
    always_ff @(posedge clock) begin
        if (ps2_fall_i && state == st_data_c) begin
            shift_q <= {ps2_data_i, shift_q[data_w_c-1:1]};
        end
    end

    assign busy_o     = (state != st_idle_c);
    // strobe on the stop fall when the stop bit is high
    assign rx_valid_o = (state == st_stop_c) & ps2_fall_i & ps2_data_i;
    assign rx_data_o  = shift_q;

    a_bit_cnt_range: assert property (@(posedge clock) disable iff (reset)
        bit_cnt < frame_bits_c);

    a_valid_in_stop: assert property (@(posedge clock) disable iff (reset)
        rx_valid_o |-> (state == st_stop_c) && (bit_cnt == frame_bits_c - 4'd1));

endmodule

//--- source/keycode_buffer.sv
/*
  Holds one keycode and the level keyboard interrupt.
  Frames that finish while the interrupt is pending are lost.
  The PS/2 clock is pulled low while a code waits or the keyboard is disabled.
*/
`timescale 1ns/10ps

module keycode_buffer import kbd_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  logic                rx_valid_i,
    input  logic [data_w_c-1:0] rx_data_i,
    input  port_b_t             port_b_i,
    output logic [data_w_c-1:0] keycode_o,
    output logic                keyboard_irq_o,
    output logic                ps2_clock_o
);

    logic irq_d;

    // next interrupt level, clear wins over a new code
    always_comb begin
        irq_d = keyboard_irq_o;
        if (port_b_i.ctl.clr) begin
            irq_d = 1'b0;
        end else if (rx_valid_i) begin
            irq_d = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            keycode_o      <= '0;
            keyboard_irq_o <= 1'b0;
            ps2_clock_o    <= 1'b0;
        end else begin
            keyboard_irq_o <= irq_d;
            // inhibit tracks the interrupt in the same cycle it rises
            ps2_clock_o    <= ~irq_d & port_b_i.ctl.kbd_en;
            if (port_b_i.ctl.clr) begin
                keycode_o <= '0;
            end else if (rx_valid_i && !keyboard_irq_o) begin
                keycode_o <= rx_data_i;
            end
        end
    end

    a_irq_after_clear: assert property (@(posedge clock) disable iff (reset)
        keyboard_irq_o |-> !$past(port_b_i.ctl.clr));

endmodule

//--- source/ppi_ports.sv
/*
  PPI window decode at 0x60-0x7F with address enable low.
  Only port B is writable, A and C are read only, offset 3 is not answered.
  Reads are combinational; writes act at every clock edge the strobe is low.
*/
`timescale 1ns/10ps

module ppi_ports import kbd_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  logic [addr_w_c-1:0] address_i,
    input  logic                address_enable_n_i,
    input  logic                io_read_n_i,
    input  logic                io_write_n_i,
    input  logic [data_w_c-1:0] data_bus_i,
    input  logic [data_w_c-1:0] port_a_i,
    input  logic [data_w_c-1:0] port_c_i,
    output port_b_t             port_b_o,
    output logic [data_w_c-1:0] data_bus_out_o,
    output logic                data_bus_out_from_chipset_o
);

    logic       window_sel;
    logic [1:0] offset;

    // bits 4..2 are not decoded, the window aliases every 4 bytes
    assign window_sel = ~address_enable_n_i & ~address_i[9] & ~address_i[8]
                      & (address_i[7:5] == ppi_window_c);
    assign offset     = address_i[1:0];

    // port B register
    always_ff @(posedge clock) begin
        if (reset) begin
            port_b_o.ctl.clr    <= 1'b0;
            port_b_o.ctl.kbd_en <= 1'b0;
            port_b_o.ctl.spare  <= 6'd0;
        end else if (window_sel && !io_write_n_i && offset == port_b_ofs_c) begin
            port_b_o.raw <= data_bus_i;
        end
    end

    // read mux
    always_comb begin
        data_bus_out_from_chipset_o = 1'b0;
        data_bus_out_o              = '0;
        if (window_sel && !io_read_n_i) begin
            case (offset)
                port_a_ofs_c: begin
                    data_bus_out_from_chipset_o = 1'b1;
                    data_bus_out_o              = port_a_i;
                end
                port_b_ofs_c: begin
                    data_bus_out_from_chipset_o = 1'b1;
                    data_bus_out_o              = port_b_o.raw;
                end
                port_c_ofs_c: begin
                    data_bus_out_from_chipset_o = 1'b1;
                    data_bus_out_o              = port_c_i;
                end
                default: begin
                    // offset 3 stays off the bus
                    data_bus_out_from_chipset_o = 1'b0;
                end
            endcase
        end
    end

endmodule

//--- source/peripherals_kbd.sv
/*
  Keyboard path of the XT peripheral block on one clock.
  Bus strobes are active-low levels and keyboard_irq_o is a level.
  ps2_clock_o low asks the keyboard to hold off.
*/
`timescale 1ns/10ps

module peripherals_kbd import kbd_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  logic [addr_w_c-1:0] address_i,
    input  logic                address_enable_n_i,
    input  logic                io_read_n_i,
    input  logic                io_write_n_i,
    input  logic [data_w_c-1:0] data_bus_i,
    output logic [data_w_c-1:0] data_bus_out_o,
    output logic                data_bus_out_from_chipset_o,
    input  logic [data_w_c-1:0] port_c_i,
    output logic [data_w_c-1:0] port_b_o,
    input  logic                ps2_clock_i,
    input  logic                ps2_data_i,
    output logic                ps2_clock_o,
    output logic                keyboard_irq_o
);

    logic                ps2_fall;
    logic                ps2_data_sync;
    logic                over_time;
    logic                rx_busy;
    logic                rx_valid;
    logic [data_w_c-1:0] rx_data;
    logic [data_w_c-1:0] keycode;
    port_b_t             port_b;

    assign port_b_o = port_b.raw;

    // pin sync, edge detect and stall watchdog
    ps2_bit_timer u_ps2_bit_timer (
        .clock           (clock),
        .reset           (reset),
        .ps2_clock_i     (ps2_clock_i),
        .ps2_data_i      (ps2_data_i),
        .busy_i          (rx_busy),
        .ps2_fall_o      (ps2_fall),
        .ps2_data_sync_o (ps2_data_sync),
        .over_time_o     (over_time)
    );

    // frame assembly
    ps2_frame_fsm u_ps2_frame_fsm (
        .clock       (clock),
        .reset       (reset),
        .ps2_fall_i  (ps2_fall),
        .ps2_data_i  (ps2_data_sync),
        .over_time_i (over_time),
        .busy_o      (rx_busy),
        .rx_valid_o  (rx_valid),
        .rx_data_o   (rx_data)
    );

    // held keycode, irq and clock inhibit
    keycode_buffer u_keycode_buffer (
        .clock          (clock),
        .reset          (reset),
        .rx_valid_i     (rx_valid),
        .rx_data_i      (rx_data),
        .port_b_i       (port_b),
        .keycode_o      (keycode),
        .keyboard_irq_o (keyboard_irq_o),
        .ps2_clock_o    (ps2_clock_o)
    );

    // 8255 subset on the CPU bus
    ppi_ports u_ppi_ports (
        .clock                       (clock),
        .reset                       (reset),
        .address_i                   (address_i),
        .address_enable_n_i          (address_enable_n_i),
        .io_read_n_i                 (io_read_n_i),
        .io_write_n_i                (io_write_n_i),
        .data_bus_i                  (data_bus_i),
        .port_a_i                    (keycode),
        .port_c_i                    (port_c_i),
        .port_b_o                    (port_b),
        .data_bus_out_o              (data_bus_out_o),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset_o)
    );

endmodule

//--- verif/tb_tasks.svh
/*
  Bus, PS/2 and check tasks, included inside the testbench module.
  Inputs change on the falling clock edge, bus reads sample 2 ns later.
*/

// full I/O address of a port inside the 0x60 window
function automatic logic [addr_w_c-1:0] port_addr(input logic [1:0] ofs);
    return {2'b00, ppi_window_c, 3'b000, ofs};
endfunction

task idle_cycles(input int n);
    repeat (n) @(negedge clock);
endtask

task check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    check_count++;
    if (got !== exp) begin
        mismatch_count++;
        $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
endtask

task check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
        mismatch_count++;
        $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
endtask

// one clock edge with the write strobe low
task io_write(input logic [addr_w_c-1:0] addr, input logic [7:0] data);
    @(negedge clock);
    address            = addr;
    address_enable_n   = 1'b0;
    data_bus           = data;
    io_write_n         = 1'b0;
    @(negedge clock);
    io_write_n         = 1'b1;
    address_enable_n   = 1'b1;
endtask

// unselected reads must leave the bus at zero
task io_read_check(input logic [addr_w_c-1:0] addr, input logic aen_n, input logic exp_sel,
                   input logic [7:0] exp_data, input string what);
    @(negedge clock);
    address          = addr;
    address_enable_n = aen_n;
    io_read_n        = 1'b0;
    #2;
    check_bit({"data_bus_out_from_chipset_o, ", what}, data_bus_out_from_chipset, exp_sel);
    check_byte({"data_bus_out_o, ", what}, data_bus_out, exp_data);
    @(negedge clock);
    io_read_n        = 1'b1;
    address_enable_n = 1'b1;
endtask

// start, 8 data LSB first, odd parity, stop; n_bits below 11 truncates
task ps2_send_frame(input logic [7:0] code, input logic bad_parity, input int n_bits);
    logic [frame_bits_c:0] frame;
    int i;
    frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
    @(negedge clock);
    for (i = 0; i < n_bits; i++) begin
        ps2_data = frame[i];
        idle_cycles(ps2_half_c);
        ps2_clock = 1'b0;
        idle_cycles(ps2_half_c);
        ps2_clock = 1'b1;
    end
    ps2_data = 1'b1;
    idle_cycles(ps2_half_c);
endtask

// irq is registered, so it is steady at the falling edge
task wait_irq(input int limit, output logic seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < limit) begin
        @(negedge clock);
        n++;
        if (keyboard_irq_o) begin
            seen = 1'b1;
        end
    end
endtask

//--- verif/tb_peripherals_kbd.sv
/*
  Directed testbench for the keyboard path: port decode, port B and PS/2 receive.
  PS/2 bits use a 20 clock half period; keycodes come from a seeded Galois LFSR.
*/
`timescale 1ns/10ps

module tb_peripherals_kbd import kbd_pkg::*; ();

    localparam int          ps2_half_c  = 20;
    localparam logic [31:0] lfsr_seed_c = 32'h2fe0_8ffa;
    localparam logic [31:0] lfsr_taps_c = 32'hd000_0001;

    // port B control values
    localparam logic [7:0]  kbd_en_c    = 8'(1 << kbd_en_bit_c);
    localparam logic [7:0]  clr_c       = 8'(1 << clr_bit_c);

    logic                clock;
    logic                reset;
    logic [addr_w_c-1:0] address;
    logic                address_enable_n;
    logic                io_read_n;
    logic                io_write_n;
    logic [data_w_c-1:0] data_bus;
    logic [data_w_c-1:0] data_bus_out;
    logic                data_bus_out_from_chipset;
    logic [data_w_c-1:0] port_c;
    logic [data_w_c-1:0] port_b_o;
    logic                ps2_clock;
    logic                ps2_data;
    logic                ps2_clock_o;
    logic                keyboard_irq_o;
    logic [31:0]         lfsr_state;
    int                  check_count = 0;
    int                  mismatch_count = 0;
    int                  failure_count = 0;

    peripherals_kbd peripherals_kbd_inst (
        .clock                       (clock),
        .reset                       (reset),
        .address_i                   (address),
        .address_enable_n_i          (address_enable_n),
        .io_read_n_i                 (io_read_n),
        .io_write_n_i                (io_write_n),
        .data_bus_i                  (data_bus),
        .data_bus_out_o              (data_bus_out),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset),
        .port_c_i                    (port_c),
        .port_b_o                    (port_b_o),
        .ps2_clock_i                 (ps2_clock),
        .ps2_data_i                  (ps2_data),
        .ps2_clock_o                 (ps2_clock_o),
        .keyboard_irq_o              (keyboard_irq_o)
    );

    `include "tb_tasks.svh"

    // one LFSR step per bit taken
    function automatic logic [7:0] next_byte();
        logic [7:0] value;
        int i;
        value = '0;
        for (i = 0; i < 8; i++) begin
            value      = {value[6:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ lfsr_taps_c) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    // clear pulse on port B, keyboard left enabled
    task clear_keycode;
        io_write(port_addr(port_b_ofs_c), clr_c | kbd_en_c);
        io_write(port_addr(port_b_ofs_c), kbd_en_c);
    endtask

    task test_after_reset;
        io_read_check(port_addr(port_b_ofs_c), 1'b0, 1'b1, 8'h00, "port B after reset");
        io_read_check(port_addr(port_a_ofs_c), 1'b0, 1'b1, 8'h00, "port A after reset");
        check_bit("ps2_clock_o", ps2_clock_o, 1'b0);
        check_bit("keyboard_irq_o", keyboard_irq_o, 1'b0);
        io_read_check(port_addr(2'd3), 1'b0, 1'b0, 8'h00, "offset 3");
        io_read_check(10'h080, 1'b0, 1'b0, 8'h00, "address 0x80");
        io_read_check(10'h161, 1'b0, 1'b0, 8'h00, "address 0x161");
        io_read_check(port_addr(port_b_ofs_c), 1'b1, 1'b0, 8'h00, "address enable high");
    endtask

    task test_port_registers;
        logic [7:0] value;
        logic [7:0] other;
        value  = next_byte();
        other  = next_byte();
        port_c = next_byte();
        io_write(port_addr(port_b_ofs_c), value);
        check_byte("port_b_o", port_b_o, value);
        io_read_check(port_addr(port_b_ofs_c), 1'b0, 1'b1, value, "port B readback");
        // A and C are read only
        io_write(port_addr(port_a_ofs_c), other);
        io_write(port_addr(port_c_ofs_c), ~other);
        check_byte("port_b_o", port_b_o, value);
        io_read_check(port_addr(port_b_ofs_c), 1'b0, 1'b1, value, "port B after A/C writes");
        io_read_check(port_addr(port_c_ofs_c), 1'b0, 1'b1, port_c, "port C");
    endtask

    task test_frame_receive;
        logic [7:0] code;
        logic       seen;
        io_write(port_addr(port_b_ofs_c), kbd_en_c);
        code = next_byte();
        ps2_send_frame(code, 1'b0, int'(frame_bits_c) + 1);
        wait_irq(200, seen);
        if (!seen) begin
            failure_count++;
            $display("No keyboard interrupt after a valid frame");
        end
        io_read_check(port_addr(port_a_ofs_c), 1'b0, 1'b1, code, "port A keycode");
        check_bit("ps2_clock_o", ps2_clock_o, 1'b0);
        clear_keycode();
        check_bit("keyboard_irq_o", keyboard_irq_o, 1'b0);
        io_read_check(port_addr(port_a_ofs_c), 1'b0, 1'b1, 8'h00, "port A after clear");
        check_bit("ps2_clock_o", ps2_clock_o, 1'b1);
    endtask

    task test_held_code;
        logic [7:0] first;
        logic [7:0] second;
        logic       seen;
        first  = next_byte();
        second = next_byte();
        if (second == first) begin
            second = ~first;
        end
        ps2_send_frame(first, 1'b0, int'(frame_bits_c) + 1);
        wait_irq(200, seen);
        if (!seen) begin
            failure_count++;
            $display("No keyboard interrupt for the first of two frames");
        end
        // keyboard ignores the inhibit here on purpose
        ps2_send_frame(second, 1'b0, int'(frame_bits_c) + 1);
        idle_cycles(10);
        io_read_check(port_addr(port_a_ofs_c), 1'b0, 1'b1, first, "port A held code");
        check_bit("keyboard_irq_o", keyboard_irq_o, 1'b1);
        clear_keycode();
    endtask

    task test_bad_frames;
        logic [7:0] code;
        logic       seen;
        code = next_byte();
        ps2_send_frame(code, 1'b1, int'(frame_bits_c) + 1);
        wait_irq(200, seen);
        if (seen) begin
            failure_count++;
            $display("Keyboard interrupt raised by a frame with bad parity");
            clear_keycode();
        end
        // start plus four data bits, then a stall past the watchdog
        ps2_send_frame(next_byte(), 1'b0, 5);
        idle_cycles(int'(ps2_over_time_c) + 50);
        code = next_byte();
        ps2_send_frame(code, 1'b0, int'(frame_bits_c) + 1);
        wait_irq(200, seen);
        if (!seen) begin
            failure_count++;
            $display("No keyboard interrupt for the frame after a truncated one");
        end
        io_read_check(port_addr(port_a_ofs_c), 1'b0, 1'b1, code, "port A after truncation");
        clear_keycode();
    endtask

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial begin
        reset            = 1'b1;
        address          = '0;
        address_enable_n = 1'b1;
        io_read_n        = 1'b1;
        io_write_n       = 1'b1;
        data_bus         = '0;
        port_c           = '0;
        ps2_clock        = 1'b1;
        ps2_data         = 1'b1;
        lfsr_state       = lfsr_seed_c;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        test_after_reset();
        test_port_registers();
        test_frame_receive();
        test_held_code();
        test_bad_frames();

        $display("checks %0d, mismatches %0d, other failures %0d",
                 check_count, mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+verif
source/kbd_pkg.sv
source/ps2_bit_timer.sv
source/ps2_frame_fsm.sv
source/keycode_buffer.sv
source/ppi_ports.sv
source/peripherals_kbd.sv
verif/tb_peripherals_kbd.sv

//--- run.sh
#!/bin/sh
# Build and run the keyboard path testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f build.f --top-module tb_peripherals_kbd

./obj_dir/Vtb_peripherals_kbd | tee sim.log

# a run that stops early on an assertion never prints the pass line
if grep -q "Done: errors found" sim.log || ! grep -q "Done: no errors" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
